// ==== hdl/router_cfg_pkg.sv ====
package router_cfg_pkg;

    // geometry of a 2D mesh router
    localparam int DEFAULT_V = 4;
    localparam int DEFAULT_P = 5;

    // flits per VC buffer downstream, so also the starting credit count
    localparam int DEFAULT_B = 4;

    // mesh port directions
    // the value is the index of the port slice in every *_all vector
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_e;

endpackage

// ==== hdl/vc_state_pkg.sv ====
package vc_state_pkg;

    // input VC ownership of an output VC
    // IVC_ASSIGNED lasts from the OVC grant until the tail flit leaves
    typedef enum logic {
        IVC_IDLE     = 1'b0,
        IVC_ASSIGNED = 1'b1
    } ivc_state_e;

endpackage

// ==== hdl/ivc_status.sv ====
`timescale 1ns/1ps

module ivc_status
    import router_cfg_pkg::*;
    import vc_state_pkg::*;
#(
    parameter int V            = DEFAULT_V,
    parameter int P            = DEFAULT_P,
    parameter int MIN_PCK_SIZE = 1
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [V*P-1:0]     flit_is_tail_all,
    input  logic [V*P-1:0]     ivc_num_getting_ovc_grant,
    input  logic [V*P*V-1:0]   granted_ovc_num_all,
    input  logic [V*P-1:0]     ivc_num_getting_sw_grant,
    output logic [V*P-1:0]     ovc_is_assigned_all,
    output logic [V*P*V-1:0]   assigned_ovc_num_all,
    output logic [V*P-1:0]     pck_is_single_flit_all,
    output logic [V*P-1:0]     credit_out_all
);

    localparam int PV = V * P;

    ivc_state_e    ivc_state      [PV];
    ivc_state_e    ivc_state_next [PV];
    logic [PV-1:0] release_ivc;

    // the tail leaving through the switch ends the ownership
    assign release_ivc = flit_is_tail_all & ivc_num_getting_sw_grant;

    always_comb begin
        for (int k = 0; k < PV; k++) begin
            ivc_state_next[k] = ivc_state[k];
            // release wins over a grant in the same cycle
            if (release_ivc[k]) begin
                ivc_state_next[k] = IVC_IDLE;
            end else if (ivc_num_getting_ovc_grant[k]) begin
                ivc_state_next[k] = IVC_ASSIGNED;
            end
            ovc_is_assigned_all[k] = (ivc_state[k] == IVC_ASSIGNED);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < PV; k++) begin
                ivc_state[k] <= IVC_IDLE;
            end
            assigned_ovc_num_all <= '0;
            credit_out_all       <= '0;
        end else begin
            for (int k = 0; k < PV; k++) begin
                ivc_state[k] <= ivc_state_next[k];
                // number is kept after release
                if (ivc_num_getting_ovc_grant[k]) begin
                    assigned_ovc_num_all[k*V +: V] <= granted_ovc_num_all[k*V +: V];
                end
            end
            // every switch grant frees one upstream buffer slot
            credit_out_all <= ivc_num_getting_sw_grant;
        end
    end

    generate
        if (MIN_PCK_SIZE == 1) begin : g_single_flit
            // head is also tail and no OVC held yet
            assign pck_is_single_flit_all = flit_is_tail_all & ~ovc_is_assigned_all;
        end else begin : g_no_single_flit
            assign pck_is_single_flit_all = '0;
        end
    endgenerate

endmodule

// ==== hdl/ovc_credit_counter.sv ====
`timescale 1ns/1ps

module ovc_credit_counter
    import router_cfg_pkg::*;
#(
    parameter int V = DEFAULT_V,
    parameter int P = DEFAULT_P,
    parameter int B = DEFAULT_B
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [V*P-1:0]         ovc_allocated_all,
    input  logic [V*P-1:0]         credit_in_all,
    input  logic [V*P-1:0]         ivc_num_getting_sw_grant,
    input  logic [P*(P-1)-1:0]     granted_dest_port_all,
    input  logic [V*P-1:0]         flit_is_tail_all,
    input  logic [V*P*V-1:0]       assigned_ovc_num_all,
    input  logic [V*P*(P-1)-1:0]   dest_port_all,
    output logic [V*P-1:0]         ovc_available_all,
    output logic [V*P-1:0]         assigned_ovc_not_full_all
);

    localparam int PV   = V * P;
    localparam int P_1  = P - 1;
    localparam int CNTW = $clog2(B + 1);

    logic [CNTW-1:0] credit_cnt [PV];
    logic [PV-1:0]   ovc_allocated;
    logic [PV-1:0]   ovc_not_full;
    logic [PV-1:0]   ovc_departure;
    logic [PV-1:0]   ovc_tail_departure;
    logic [V-1:0]    iport_ovc  [P];
    logic [P-1:0]    iport_dest [P];
    logic [P-1:0]    iport_tail;

    // destination vectors skip the own port, put it back in
    function automatic logic [P-1:0] to_abs_port(input logic [P_1-1:0] rel, input int own);
        logic [P-1:0] abs_port;
        abs_port = '0;
        for (int o = 0; o < P; o++) begin
            if (o < own) begin
                abs_port[o] = rel[o];
            end else if (o > own) begin
                abs_port[o] = rel[o-1];
            end
        end
        return abs_port;
    endfunction

    // per input port: OVC of the switch-granted IVC and its tail bit
    always_comb begin
        for (int i = 0; i < P; i++) begin
            iport_ovc[i]  = '0;
            iport_tail[i] = 1'b0;
            for (int v = 0; v < V; v++) begin
                if (ivc_num_getting_sw_grant[i*V+v]) begin
                    iport_ovc[i]  = iport_ovc[i] | assigned_ovc_num_all[(i*V+v)*V +: V];
                    iport_tail[i] = iport_tail[i] | flit_is_tail_all[i*V+v];
                end
            end
            iport_dest[i] = to_abs_port(granted_dest_port_all[i*P_1 +: P_1], i);
        end
    end

    always_comb begin
        ovc_departure      = '0;
        ovc_tail_departure = '0;
        for (int i = 0; i < P; i++) begin
            for (int o = 0; o < P; o++) begin
                for (int v = 0; v < V; v++) begin
                    if (iport_dest[i][o] && iport_ovc[i][v]) begin
                        ovc_departure[o*V+v]      = 1'b1;
                        ovc_tail_departure[o*V+v] = iport_tail[i];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int n = 0; n < PV; n++) begin
                credit_cnt[n] <= CNTW'(B);
            end
            ovc_allocated <= '0;
        end else begin
            for (int n = 0; n < PV; n++) begin
                // departure and credit together cancel out
                if (ovc_departure[n] && !credit_in_all[n]) begin
                    credit_cnt[n] <= credit_cnt[n] - 1'b1;
                end else if (!ovc_departure[n] && credit_in_all[n]) begin
                    credit_cnt[n] <= credit_cnt[n] + 1'b1;
                end
                if (ovc_allocated_all[n]) begin
                    ovc_allocated[n] <= 1'b1;
                end else if (ovc_tail_departure[n]) begin
                    ovc_allocated[n] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int n = 0; n < PV; n++) begin
            ovc_not_full[n] = (credit_cnt[n] != '0);
        end
    end

    assign ovc_available_all = ~ovc_allocated;

    // each IVC sees the space left in its own OVC at its destination
    always_comb begin : not_full_map
        logic [P-1:0] dest_abs;
        for (int k = 0; k < PV; k++) begin
            dest_abs = to_abs_port(dest_port_all[k*P_1 +: P_1], k / V);
            assigned_ovc_not_full_all[k] = 1'b0;
            for (int o = 0; o < P; o++) begin
                for (int v = 0; v < V; v++) begin
                    if (dest_abs[o] && assigned_ovc_num_all[k*V+v] && ovc_not_full[o*V+v]) begin
                        assigned_ovc_not_full_all[k] = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/vc_request_mask.sv ====
`timescale 1ns/1ps

module vc_request_mask
    import router_cfg_pkg::*;
#(
    parameter int V = DEFAULT_V,
    parameter int P = DEFAULT_P
) (
    input  logic [V*P-1:0]         ivc_request_all,
    input  logic [V*P-1:0]         ovc_is_assigned_all,
    input  logic [V*P*(P-1)-1:0]   dest_port_all,
    input  logic [V*P*V-1:0]       candidate_ovc_all,
    input  logic [V*P-1:0]         ovc_available_all,
    output logic [V*P*V-1:0]       masked_ovc_request_all
);

    localparam int PV   = V * P;
    localparam int P_1  = P - 1;
    localparam int VP_1 = V * P_1;

    logic [PV-1:0]   unassigned_request;
    logic [VP_1-1:0] avail_other_ports [P];

    // only IVCs still waiting for an OVC may request one
    assign unassigned_request = ivc_request_all & ~ovc_is_assigned_all;

    // drop the availability bits of the port the IVC sits in
    genvar i;
    generate
        for (i = 0; i < P; i++) begin : g_port
            if (i == LOCAL) begin : g_first
                assign avail_other_ports[i] = ovc_available_all[PV-1:V];
            end else if (i == P - 1) begin : g_last
                assign avail_other_ports[i] = ovc_available_all[PV-V-1:0];
            end else begin : g_middle
                assign avail_other_ports[i] = {ovc_available_all[PV-1:(i+1)*V],
                                               ovc_available_all[i*V-1:0]};
            end
        end
    endgenerate

    always_comb begin : mask_requests
        logic [V-1:0] avail_muxed;
        for (int k = 0; k < PV; k++) begin
            // and-or one-hot mux over the destination port
            avail_muxed = '0;
            for (int j = 0; j < P_1; j++) begin
                avail_muxed = avail_muxed |
                              ({V{dest_port_all[k*P_1+j]}} & avail_other_ports[k/V][j*V +: V]);
            end
            if (unassigned_request[k]) begin
                masked_ovc_request_all[k*V +: V] = candidate_ovc_all[k*V +: V] & avail_muxed;
            end else begin
                masked_ovc_request_all[k*V +: V] = '0;
            end
        end
    end

endmodule

// ==== hdl/router_vc_control.sv ====
`timescale 1ns/1ps

module router_vc_control
    import router_cfg_pkg::*;
#(
    parameter int V            = DEFAULT_V,
    parameter int P            = DEFAULT_P,
    parameter int B            = DEFAULT_B,
    parameter int MIN_PCK_SIZE = 1
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [V*P-1:0]         ivc_request_all,
    input  logic [V*P*(P-1)-1:0]   dest_port_all,
    input  logic [V*P*V-1:0]       candidate_ovc_all,
    input  logic [V*P-1:0]         flit_is_tail_all,
    input  logic [V*P-1:0]         ivc_num_getting_ovc_grant,
    input  logic [V*P*V-1:0]       granted_ovc_num_all,
    input  logic [V*P-1:0]         ovc_allocated_all,
    input  logic [V*P-1:0]         ivc_num_getting_sw_grant,
    input  logic [P*(P-1)-1:0]     granted_dest_port_all,
    input  logic [V*P-1:0]         credit_in_all,
    output logic [V*P-1:0]         credit_out_all,
    output logic [V*P-1:0]         ovc_is_assigned_all,
    output logic [V*P-1:0]         pck_is_single_flit_all,
    output logic [V*P-1:0]         ovc_available_all,
    output logic [V*P-1:0]         assigned_ovc_not_full_all,
    output logic [V*P*V-1:0]       masked_ovc_request_all
);

    localparam int PV  = V * P;
    localparam int PVV = PV * V;

    // one-hot OVC held by each IVC
    logic [PVV-1:0] assigned_ovc_num_all;

    ivc_status #(
        .V            (V),
        .P            (P),
        .MIN_PCK_SIZE (MIN_PCK_SIZE)
    ) i_ivc_status (
        .clk                       (clk),
        .reset                     (reset),
        .flit_is_tail_all          (flit_is_tail_all),
        .ivc_num_getting_ovc_grant (ivc_num_getting_ovc_grant),
        .granted_ovc_num_all       (granted_ovc_num_all),
        .ivc_num_getting_sw_grant  (ivc_num_getting_sw_grant),
        .ovc_is_assigned_all       (ovc_is_assigned_all),
        .assigned_ovc_num_all      (assigned_ovc_num_all),
        .pck_is_single_flit_all    (pck_is_single_flit_all),
        .credit_out_all            (credit_out_all[PV-1:0])
    );

    ovc_credit_counter #(
        .V (V),
        .P (P),
        .B (B)
    ) i_ovc_credit_counter (
        .clk                       (clk),
        .reset                     (reset),
        .ovc_allocated_all         (ovc_allocated_all),
        .credit_in_all             (credit_in_all),
        .ivc_num_getting_sw_grant  (ivc_num_getting_sw_grant),
        .granted_dest_port_all     (granted_dest_port_all),
        .flit_is_tail_all          (flit_is_tail_all),
        .assigned_ovc_num_all      (assigned_ovc_num_all),
        .dest_port_all             (dest_port_all),
        .ovc_available_all         (ovc_available_all),
        .assigned_ovc_not_full_all (assigned_ovc_not_full_all)
    );

    vc_request_mask #(
        .V (V),
        .P (P)
    ) i_vc_request_mask (
        .ivc_request_all        (ivc_request_all),
        .ovc_is_assigned_all    (ovc_is_assigned_all),
        .dest_port_all          (dest_port_all),
        .candidate_ovc_all      (candidate_ovc_all),
        .ovc_available_all      (ovc_available_all),
        .masked_ovc_request_all (masked_ovc_request_all)
    );

endmodule

// ==== verification/router_vc_control_assertions.sv ====
`timescale 1ns/1ps

module router_vc_control_assertions
    import router_cfg_pkg::*;
    import vc_state_pkg::*;
#(
    parameter int V = DEFAULT_V,
    parameter int P = DEFAULT_P
) (
    input logic                   clk,
    input logic                   reset,
    input logic [V*P-1:0]         ivc_request_all,
    input logic [V*P*(P-1)-1:0]   dest_port_all,
    input logic [V*P*V-1:0]       candidate_ovc_all,
    input logic [V*P-1:0]         flit_is_tail_all,
    input logic [V*P-1:0]         ivc_num_getting_ovc_grant,
    input logic [V*P-1:0]         ivc_num_getting_sw_grant,
    input logic [V*P-1:0]         ovc_allocated_all,
    input logic [V*P-1:0]         credit_out_all,
    input logic [V*P-1:0]         ovc_is_assigned_all,
    input logic [V*P-1:0]         ovc_available_all,
    input logic [V*P*V-1:0]       masked_ovc_request_all
);

    localparam int PV = V * P;

    int              error_count = 0;
    logic [PV-1:0]   assigned_next;
    logic [PV*V-1:0] expect_mask;

    // IVC_IDLE to IVC_ASSIGNED on an OVC grant, back to IVC_IDLE on a departing tail
    always_comb begin : next_state
        ivc_state_e state;
        for (int k = 0; k < PV; k++) begin
            state = ovc_is_assigned_all[k] ? IVC_ASSIGNED : IVC_IDLE;
            if (flit_is_tail_all[k] && ivc_num_getting_sw_grant[k]) begin
                state = IVC_IDLE;
            end else if (ivc_num_getting_ovc_grant[k]) begin
                state = IVC_ASSIGNED;
            end
            assigned_next[k] = (state == IVC_ASSIGNED);
        end
    end

    // candidates gated by the availability at the destination port
    always_comb begin : mask_model
        int dst;
        for (int k = 0; k < PV; k++) begin
            expect_mask[k*V +: V] = '0;
            for (int j = 0; j < P - 1; j++) begin
                // destination index skips the own port
                dst = (j < k / V) ? j : j + 1;
                if (dest_port_all[k*(P-1)+j] && ivc_request_all[k] && !ovc_is_assigned_all[k]) begin
                    expect_mask[k*V +: V] = candidate_ovc_all[k*V +: V] & ovc_available_all[dst*V +: V];
                end
            end
        end
    end

    a_reset_values: assert property (@(posedge clk) reset |=>
        credit_out_all == '0 && ovc_is_assigned_all == '0 && ovc_available_all == '1)
        else begin
            error_count++;
            $error("outputs do not hold their reset values after reset");
        end

    a_credit_return: assert property (@(posedge clk) disable iff (reset)
        credit_out_all == $past(ivc_num_getting_sw_grant))
        else begin
            error_count++;
            $error("credit_out_all is not the switch grant of the previous cycle");
        end

    a_ovc_assignment: assert property (@(posedge clk) disable iff (reset)
        ovc_is_assigned_all == $past(assigned_next))
        else begin
            error_count++;
            $error("ovc_is_assigned_all did not follow the OVC grants and departing tails");
        end

    a_ovc_allocation: assert property (@(posedge clk) disable iff (reset)
        ovc_allocated_all != '0 |=> (ovc_available_all & $past(ovc_allocated_all)) == '0)
        else begin
            error_count++;
            $error("an allocated OVC is still reported available");
        end

    a_request_mask: assert property (@(posedge clk) disable iff (reset)
        masked_ovc_request_all == expect_mask)
        else begin
            error_count++;
            $error("masked_ovc_request_all does not match the available candidate OVCs");
        end

endmodule

bind router_vc_control router_vc_control_assertions #(.V(V), .P(P)) i_assertions (.*);

// ==== verification/tb_router_vc_control.sv ====
`timescale 1ns/1ps

module tb_router_vc_control
    import router_cfg_pkg::*;
();

    localparam int V          = DEFAULT_V;
    localparam int P          = DEFAULT_P;
    localparam int B          = DEFAULT_B;
    localparam int PV         = V * P;
    localparam int P_1        = P - 1;
    localparam int VALUE_W    = 3 * PV;
    localparam int CLK_PERIOD = 100;
    // IVC 1 of the local port, and the last IVC of the south port
    localparam int IVC_K      = 1;
    localparam int MASK_IVC   = PV - 1;
    localparam int EAST_OVC   = int'(EAST) * V + 3;
    localparam logic [PV-1:0] NORTH_OVCS = PV'({V{1'b1}}) << (int'(NORTH) * V);
    // cycles per test with the longest random gaps
    localparam int TEST_CYCLES = 2 + 4 + 21 * 4 + 1 + 3 + (B + 2) + 1 + 32;

    logic               clk;
    logic               reset;
    logic [PV-1:0]      ivc_request_all;
    logic [PV*P_1-1:0]  dest_port_all;
    logic [PV*V-1:0]    candidate_ovc_all;
    logic [PV-1:0]      flit_is_tail_all;
    logic [PV-1:0]      ivc_num_getting_ovc_grant;
    logic [PV*V-1:0]    granted_ovc_num_all;
    logic [PV-1:0]      ovc_allocated_all;
    logic [PV-1:0]      ivc_num_getting_sw_grant;
    logic [P*P_1-1:0]   granted_dest_port_all;
    logic [PV-1:0]      credit_in_all;
    logic [PV-1:0]      credit_out_all;
    logic [PV-1:0]      ovc_is_assigned_all;
    logic [PV-1:0]      pck_is_single_flit_all;
    logic [PV-1:0]      ovc_available_all;
    logic [PV-1:0]      assigned_ovc_not_full_all;
    logic [PV*V-1:0]    masked_ovc_request_all;

    // expected OVC availability and credits
    logic [PV-1:0]      avail_model;
    int                 credit_model [PV];
    int                 passed;
    int                 failed;

    router_vc_control #(.MIN_PCK_SIZE(1)) i_router_vc_control (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("watchdog expired before all tests had finished");
        $display("Regression failed");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // one-hot destination without the own port
    function automatic logic [P_1-1:0] rel_port(input int dst, input int own);
        logic [P_1-1:0] rel;
        rel = '0;
        rel[(dst < own) ? dst : dst - 1] = 1'b1;
        return rel;
    endfunction

    task automatic compare_result(input string name, input logic [VALUE_W-1:0] actual,
                                  input logic [VALUE_W-1:0] expected);
        if (expected !== actual) begin
            failed++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end else begin
            passed++;
            $display("%s passed", name);
        end
    endtask

    task automatic grant_ovc(input int k, input int ovc);
        ivc_num_getting_ovc_grant[k] = 1'b1;
        granted_ovc_num_all[k*V +: V] = V'(1) << ovc;
        next_cycle();
        ivc_num_getting_ovc_grant[k] = 1'b0;
    endtask

    // one flit of IVC k through the switch towards OVC ovc of port dst
    task automatic send_flit(input int k, input int dst, input int ovc, input logic tail);
        ivc_num_getting_sw_grant[k] = 1'b1;
        flit_is_tail_all[k] = tail;
        granted_dest_port_all[(k / V) * P_1 +: P_1] = rel_port(dst, k / V);
        next_cycle();
        ivc_num_getting_sw_grant[k] = 1'b0;
        flit_is_tail_all[k] = 1'b0;
        granted_dest_port_all = '0;
        credit_model[dst*V+ovc]--;
        if (tail) begin
            avail_model[dst*V+ovc] = 1'b1;
        end
    endtask

    initial begin : run_tests
        logic [PV-1:0] pattern;
        logic [PV-1:0] expect_vec;
        logic [1:0]    not_full_seen;
        int            assert_errors;
        void'($urandom(32'h42e0_021a));
        passed = 0;
        failed = 0;
        reset = 1'b1;
        ivc_request_all = '0;
        dest_port_all = '0;
        candidate_ovc_all = '0;
        flit_is_tail_all = '0;
        ivc_num_getting_ovc_grant = '0;
        granted_ovc_num_all = '0;
        ovc_allocated_all = '0;
        ivc_num_getting_sw_grant = '0;
        granted_dest_port_all = '0;
        credit_in_all = '0;
        avail_model = '1;
        foreach (credit_model[n]) begin
            credit_model[n] = B;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        dest_port_all[IVC_K*P_1 +: P_1] = rel_port(int'(EAST), int'(LOCAL));
        compare_result("reset_values", {credit_out_all, ovc_is_assigned_all, ovc_available_all},
                       {{(2 * PV){1'b0}}, {PV{1'b1}}});

        // held through body flits, dropped by the tail
        grant_ovc(IVC_K, 2);
        send_flit(IVC_K, int'(EAST), 2, 1'b0);
        send_flit(IVC_K, int'(EAST), 2, 1'b0);
        pattern = ovc_is_assigned_all;
        send_flit(IVC_K, int'(EAST), 2, 1'b1);
        expect_vec = '0;
        expect_vec[IVC_K] = 1'b1;
        compare_result("ovc_assignment", VALUE_W'({pattern, ovc_is_assigned_all}),
                       VALUE_W'({expect_vec, {PV{1'b0}}}));

        // at most one switch grant per input port
        repeat (21) begin
            pattern = '0;
            for (int i = 0; i < P; i++) begin
                if ($urandom_range(0, 1) != 0) begin
                    pattern[i*V + int'($urandom_range(0, V - 1))] = 1'b1;
                end
            end
            ivc_num_getting_sw_grant = pattern;
            next_cycle();
            ivc_num_getting_sw_grant = '0;
            expect_vec = credit_out_all;
            repeat ($urandom_range(0, 3)) next_cycle();
        end
        compare_result("credit_return", VALUE_W'(expect_vec), VALUE_W'(pattern));

        ovc_allocated_all[EAST_OVC] = 1'b1;
        next_cycle();
        ovc_allocated_all = '0;
        avail_model[EAST_OVC] = 1'b0;
        expect_vec = avail_model;
        pattern = ovc_available_all;
        grant_ovc(IVC_K, 3);
        send_flit(IVC_K, int'(EAST), 3, 1'b1);
        compare_result("ovc_allocation", VALUE_W'({pattern, ovc_available_all}),
                       VALUE_W'({expect_vec, avail_model}));

        // drain every credit of east OVC 3, then return one
        grant_ovc(IVC_K, 3);
        while (credit_model[EAST_OVC] > 0) begin
            send_flit(IVC_K, int'(EAST), 3, 1'b0);
        end
        not_full_seen[1] = assigned_ovc_not_full_all[IVC_K];
        credit_in_all[EAST_OVC] = 1'b1;
        next_cycle();
        credit_in_all = '0;
        credit_model[EAST_OVC]++;
        not_full_seen[0] = assigned_ovc_not_full_all[IVC_K];
        compare_result("credit_exhaustion", VALUE_W'(not_full_seen), VALUE_W'(2'b01));

        // IVC 2 is idle, IVC_K still holds its OVC
        flit_is_tail_all[2] = 1'b1;
        flit_is_tail_all[IVC_K] = 1'b1;
        #10;
        compare_result("single_flit",
                       VALUE_W'({pck_is_single_flit_all[2], pck_is_single_flit_all[IVC_K]}),
                       VALUE_W'(2'b10));
        flit_is_tail_all = '0;
        next_cycle();

        // north port stays free of random allocations
        repeat (30) begin
            ivc_request_all = PV'($urandom);
            ovc_allocated_all = PV'($urandom) & PV'($urandom) & PV'($urandom) & ~NORTH_OVCS;
            for (int k = 0; k < PV; k++) begin
                candidate_ovc_all[k*V +: V] = V'($urandom_range(0, (1 << V) - 1));
                dest_port_all[k*P_1 +: P_1] = P_1'(1) << $urandom_range(0, P - 2);
            end
            next_cycle();
            avail_model = avail_model & ~ovc_allocated_all;
        end
        // one north OVC taken, the rest still free
        ovc_allocated_all = '0;
        ovc_allocated_all[int'(NORTH)*V + 1] = 1'b1;
        ivc_request_all[MASK_IVC] = 1'b1;
        dest_port_all[MASK_IVC*P_1 +: P_1] = rel_port(int'(NORTH), int'(SOUTH));
        candidate_ovc_all[MASK_IVC*V +: V] = '1;
        next_cycle();
        ovc_allocated_all = '0;
        avail_model[int'(NORTH)*V + 1] = 1'b0;
        #10;
        compare_result("request_masking", VALUE_W'(masked_ovc_request_all[MASK_IVC*V +: V]),
                       VALUE_W'(candidate_ovc_all[MASK_IVC*V +: V] &
                                avail_model[int'(NORTH)*V +: V]));
        next_cycle();

        assert_errors = i_router_vc_control.i_assertions.error_count;
        $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
                 passed, failed, assert_errors);
        if (failed == 0 && assert_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== router_vc_control.f ====
hdl/router_cfg_pkg.sv
hdl/vc_state_pkg.sv
hdl/ivc_status.sv
hdl/ovc_credit_counter.sv
hdl/vc_request_mask.sv
hdl/router_vc_control.sv
verification/router_vc_control_assertions.sv
verification/tb_router_vc_control.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_router_vc_control \
		-f router_vc_control.f --Mdir obj_dir -o sim

run: compile
	./obj_dir/sim +verilator+error+limit+1000 | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
